// ==== include/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Cache geometry
// 8 sets of two ways, two words per block

// Number of sets
`define DCACHE_SETS 8

// Words held by one block
`define DCACHE_BLK_WORDS 2

// Set index width in address bits
`define DCACHE_IDX_W 3

// Tag width, every address bit above the index
`define DCACHE_TAG_W 26

// Data word and byte address width
`define DCACHE_WORD_W 32

// Byte offset bits below the block offset
`define DCACHE_BYTE_W 2

// Address layout, high to low
// tag | index | block offset | byte offset

// Hit statistic lands here at the end of a flush
`define DCACHE_COUNT_ADDR 32'h0000_3100

`endif

// ==== verilog/dcache_pkg.sv ====
`include "dcache_cfg.svh"

package dcache_pkg;

	// Data word, also used for byte addresses
	typedef logic [`DCACHE_WORD_W-1:0] word_t;

	// Tag field of an address
	typedef logic [`DCACHE_TAG_W-1:0] dtag_t;

	// Set index field of an address
	typedef logic [`DCACHE_IDX_W-1:0] idx_t;

	// Way number, 0 is the first way
	typedef logic way_t;

	////////////////////
	// Controller states
	////////////////////
	typedef enum logic [3:0] {
		// Serving hits, waiting for a request
		s_idle,
		// Dirty victim write back, two words
		s_wb0,
		s_wb1,
		// Block fetch, two words
		s_fd0,
		s_fd1,
		// Flush loop head, looks for a dirty entry
		s_dchk,
		// Flush write back of one dirty entry
		s_fwb0,
		s_fwb1,
		// Statistic write
		s_wrcnt,
		// Done, held until reset
		s_flushed
	} dstate_t;

endpackage

// ==== verilog/dcache_array.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_array (
	input  logic                CLK,
	input  logic                nRST,
	input  dcache_pkg::word_t   addr,
	input  dcache_pkg::word_t   store_data,
	input  dcache_pkg::word_t   load_data,
	input  logic                store_en,
	input  logic                fill_en,
	input  logic                word_sel,
	input  logic                flush_sel,
	input  logic                clean_en,
	input  logic                count_sel,
	input  dcache_pkg::word_t   count,
	input  dcache_pkg::way_t    victim_way,
	output logic                tag_match,
	output dcache_pkg::way_t    hit_way,
	output logic                victim_dirty,
	output logic                some_dirty,
	output dcache_pkg::word_t   mem_addr,
	output dcache_pkg::word_t   mem_data,
	output dcache_pkg::word_t   read_data
);
	import dcache_pkg::*;

	// Field positions inside the address
	localparam int OFF_BIT = `DCACHE_BYTE_W;
	localparam int IDX_LO = `DCACHE_BYTE_W + 1;

	// Request address fields
	dtag_t a_tag;
	idx_t  a_idx;
	logic  a_off;

	// Storage, per set and way
	logic  valid_q [`DCACHE_SETS][2];
	logic  dirty_q [`DCACHE_SETS][2];
	dtag_t tag_q [`DCACHE_SETS][2];
	word_t data_q [`DCACHE_SETS][2][`DCACHE_BLK_WORDS];

	logic match0;
	logic match1;

	// Highest dirty entry found by the scan
	idx_t scan_idx;
	way_t scan_way;

	// Entry that feeds the memory side
	idx_t wb_idx;
	way_t wb_way;

	assign a_tag = addr[`DCACHE_WORD_W-1 -: `DCACHE_TAG_W];
	assign a_idx = addr[IDX_LO +: `DCACHE_IDX_W];
	assign a_off = addr[OFF_BIT];

	////////////////////
	// Lookup
	////////////////////
	assign match0 = valid_q[a_idx][0] && (tag_q[a_idx][0] == a_tag);
	assign match1 = valid_q[a_idx][1] && (tag_q[a_idx][1] == a_tag);
	assign tag_match = match0 || match1;
	// Both ways never hold the same tag
	assign hit_way = way_t'(match1);
	assign read_data = data_q[a_idx][hit_way][a_off];
	assign victim_dirty = dirty_q[a_idx][victim_way];

	////////////////////
	// Dirty scan
	////////////////////
	always_comb begin
		scan_idx = '0;
		scan_way = '0;
		some_dirty = 1'b0;
		// Later entries override, so the highest one wins
		for (int s = 0; s < `DCACHE_SETS; s++) begin
			for (int w = 0; w < 2; w++) begin
				if (dirty_q[s][w]) begin
					scan_idx = idx_t'(s);
					scan_way = way_t'(w);
					some_dirty = 1'b1;
				end
			end
		end
	end

	////////////////////
	// Memory side
	////////////////////
	// Flush takes the scanned entry, a miss takes the victim
	assign wb_idx = flush_sel ? scan_idx : a_idx;
	assign wb_way = flush_sel ? scan_way : victim_way;

	always_comb begin
		if (count_sel) begin
			mem_addr = `DCACHE_COUNT_ADDR;
		end else if (flush_sel || victim_dirty) begin
			// Write back of the stored block
			mem_addr = {tag_q[wb_idx][wb_way], wb_idx, word_sel, {`DCACHE_BYTE_W{1'b0}}};
		end else begin
			// Fetch of the requested block
			mem_addr = {a_tag, a_idx, word_sel, {`DCACHE_BYTE_W{1'b0}}};
		end
	end

	assign mem_data = count_sel ? count : data_q[wb_idx][wb_way][word_sel];

	////////////////////
	// State bits
	////////////////////
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < `DCACHE_SETS; s++) begin
				for (int w = 0; w < 2; w++) begin
					valid_q[s][w] <= 1'b0;
					dirty_q[s][w] <= 1'b0;
				end
			end
		end else begin
			// Write hit marks the block dirty
			if (store_en) begin
				dirty_q[a_idx][hit_way] <= 1'b1;
			end
			// Fill leaves a clean valid block
			if (fill_en) begin
				valid_q[a_idx][victim_way] <= 1'b1;
				dirty_q[a_idx][victim_way] <= 1'b0;
			end
			// Last word of a write back done
			if (clean_en) begin
				dirty_q[wb_idx][wb_way] <= 1'b0;
			end
		end
	end

	// Tags and words
	always_ff @(posedge CLK) begin
		if (store_en) begin
			data_q[a_idx][hit_way][a_off] <= store_data;
		end
		if (fill_en) begin
			data_q[a_idx][victim_way][word_sel] <= load_data;
			tag_q[a_idx][victim_way] <= a_tag;
		end
	end

endmodule

// ==== verilog/dcache_lru.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_lru (
	input  logic               CLK,
	input  logic               nRST,
	input  dcache_pkg::idx_t   idx,
	input  logic               touch,
	input  dcache_pkg::way_t   used_way,
	output dcache_pkg::way_t   victim_way
);
	import dcache_pkg::*;

	// One bit per set, names the least recently used way
	way_t lru_q [`DCACHE_SETS];

	////////////////////
	// Update on hit
	////////////////////
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int s = 0; s < `DCACHE_SETS; s++) begin
				lru_q[s] <= 1'b0;
			end
		end else if (touch) begin
			// The other way becomes the oldest
			lru_q[idx] <= ~used_way;
		end
	end

	// Victim for the set being addressed
	assign victim_way = lru_q[idx];

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                CLK,
	input  logic                nRST,
	input  logic                halt,
	input  logic                dmemREN,
	input  logic                dmemWEN,
	input  logic                tag_match,
	input  logic                victim_dirty,
	input  logic                some_dirty,
	input  logic                dwait,
	output logic                dhit,
	output logic                store_en,
	output logic                fill_en,
	output logic                word_sel,
	output logic                flush_sel,
	output logic                clean_en,
	output logic                count_sel,
	output logic                dREN,
	output logic                dWEN,
	output logic                flushed,
	output dcache_pkg::word_t   count
);
	import dcache_pkg::*;

	dstate_t state;
	dstate_t next_state;

	logic req;
	// Memory beat finishes this cycle
	logic beat_done;

	// Statistic counters
	word_t hit_cnt;
	word_t miss_cnt;

	assign req = dmemREN || dmemWEN;
	assign beat_done = !dwait;

	// Hits only served while idle
	assign dhit = (state == s_idle) && req && tag_match;
	assign store_en = dhit && dmemWEN;

	////////////////////
	// Next state
	////////////////////
	always_comb begin
		next_state = state;
		case (state)
			s_idle: begin
				if (req && !tag_match) begin
					// Dirty victim goes out before the fetch
					next_state = victim_dirty ? s_wb0 : s_fd0;
				end else if (!req && halt) begin
					next_state = s_dchk;
				end
			end
			s_wb0: if (beat_done) next_state = s_wb1;
			s_wb1: if (beat_done) next_state = s_fd0;
			s_fd0: if (beat_done) next_state = s_fd1;
			// Back to idle, request then hits
			s_fd1: if (beat_done) next_state = s_idle;
			s_dchk: next_state = some_dirty ? s_fwb0 : s_wrcnt;
			s_fwb0: if (beat_done) next_state = s_fwb1;
			s_fwb1: if (beat_done) next_state = s_dchk;
			s_wrcnt: if (beat_done) next_state = s_flushed;
			s_flushed: next_state = s_flushed;
			default: next_state = s_idle;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= s_idle;
		end else begin
			state <= next_state;
		end
	end

	////////////////////
	// Outputs
	////////////////////
	assign dREN = (state == s_fd0) || (state == s_fd1);
	assign dWEN = (state == s_wb0) || (state == s_wb1) || (state == s_fwb0)
		|| (state == s_fwb1) || (state == s_wrcnt);
	// Second word of a block
	assign word_sel = (state == s_wb1) || (state == s_fd1) || (state == s_fwb1);
	assign flush_sel = (state == s_fwb0) || (state == s_fwb1);
	assign count_sel = (state == s_wrcnt);
	assign flushed = (state == s_flushed);
	// Strobes only on the completing edge
	assign fill_en = dREN && beat_done;
	// Victim is cleaned too, so the fetch then uses the request address
	assign clean_en = ((state == s_fwb1) || (state == s_wb1)) && beat_done;

	////////////////////
	// Hit statistic
	////////////////////
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			hit_cnt <= '0;
			miss_cnt <= '0;
		end else begin
			if (dhit) begin
				hit_cnt <= hit_cnt + 1'b1;
			end
			// One per fetch started, cancels the hit after the fill
			if ((next_state == s_fd0) && (state != s_fd0)) begin
				miss_cnt <= miss_cnt + 1'b1;
			end
		end
	end

	// First try hits
	assign count = hit_cnt - miss_cnt;

endmodule

// ==== verilog/dcache.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache (
	input  logic                CLK,
	input  logic                nRST,
	input  logic                halt,
	input  logic                dmemREN,
	input  logic                dmemWEN,
	input  dcache_pkg::word_t   dmemaddr,
	input  dcache_pkg::word_t   dmemstore,
	output logic                dhit,
	output dcache_pkg::word_t   dmemload,
	output logic                flushed,
	input  logic                dwait,
	input  dcache_pkg::word_t   dload,
	output logic                dREN,
	output logic                dWEN,
	output dcache_pkg::word_t   daddr,
	output dcache_pkg::word_t   dstore
);
	import dcache_pkg::*;

	// Array status
	logic tag_match;
	logic victim_dirty;
	logic some_dirty;
	way_t hit_way;
	way_t victim_way;

	// Controller strobes
	logic store_en;
	logic fill_en;
	logic word_sel;
	logic flush_sel;
	logic clean_en;
	logic count_sel;
	word_t count;

	// Set index of the request
	idx_t idx;

	assign idx = dmemaddr[`DCACHE_BYTE_W + 1 +: `DCACHE_IDX_W];

	dcache_array i_array (
		.CLK(CLK), .nRST(nRST), .addr(dmemaddr), .store_data(dmemstore),
		.load_data(dload), .store_en(store_en), .fill_en(fill_en), .word_sel(word_sel),
		.flush_sel(flush_sel), .clean_en(clean_en), .count_sel(count_sel), .count(count),
		.victim_way(victim_way), .tag_match(tag_match), .hit_way(hit_way),
		.victim_dirty(victim_dirty), .some_dirty(some_dirty), .mem_addr(daddr),
		.mem_data(dstore), .read_data(dmemload)
	);

	// A hit marks its way as most recent
	dcache_lru i_lru (
		.CLK(CLK), .nRST(nRST), .idx(idx), .touch(dhit), .used_way(hit_way),
		.victim_way(victim_way)
	);

	dcache_ctrl i_ctrl (
		.CLK(CLK), .nRST(nRST), .halt(halt), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
		.tag_match(tag_match), .victim_dirty(victim_dirty), .some_dirty(some_dirty),
		.dwait(dwait), .dhit(dhit), .store_en(store_en), .fill_en(fill_en),
		.word_sel(word_sel), .flush_sel(flush_sel), .clean_en(clean_en),
		.count_sel(count_sel), .dREN(dREN), .dWEN(dWEN), .flushed(flushed), .count(count)
	);

endmodule

// ==== verification/dcache_props.sv ====
`timescale 1ns/1ps

module dcache_props (
	input logic                CLK,
	input logic                nRST,
	input logic                dREN,
	input logic                dWEN,
	input logic                flushed,
	input dcache_pkg::word_t   daddr
);

	// Failed assertions so far, read by the testbench
	int fail_count = 0;

	////////////////////
	// Memory side
	////////////////////
	// One direction per beat
	a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
		else begin
			$error("dREN and dWEN high together");
			fail_count++;
		end

	// Word aligned memory address
	a_aligned: assert property (@(posedge CLK) disable iff (!nRST)
		(dREN || dWEN) |-> (daddr[1:0] == 2'b00))
		else begin
			$error("daddr not word aligned during a beat");
			fail_count++;
		end

	// Flush done is held until reset
	a_flushed_held: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
		else begin
			$error("flushed dropped");
			fail_count++;
		end

endmodule

bind dcache dcache_props i_props (
	.CLK(CLK), .nRST(nRST), .dREN(dREN), .dWEN(dWEN), .flushed(flushed), .daddr(daddr)
);

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;
	import dcache_pkg::*;

	// Operation codes of the stimulus table
	localparam int OP_RD = 0;
	localparam int OP_WR = 1;
	localparam int OP_MEM = 2;
	localparam int OP_HALT = 3;

	// One cycle limit per kind of wait
	localparam int HIT_TIMEOUT = 100;
	localparam int FLUSH_TIMEOUT = 500;

	// A word never written reads as its address xor this
	localparam word_t MEM_XOR = 32'hC0DE_F00D;

	logic  CLK = 1'b0;
	logic  nRST;
	logic  halt;
	logic  dmemREN;
	logic  dmemWEN;
	word_t dmemaddr;
	word_t dmemstore;
	logic  dhit;
	word_t dmemload;
	logic  flushed;
	logic  dwait = 1'b1;
	word_t dload = '0;
	logic  dREN;
	logic  dWEN;
	word_t daddr;
	word_t dstore;

	// Memory model contents and the processor view of memory
	word_t mem [word_t];
	word_t ref_mem [word_t];

	// Stimulus table columns
	int    tab_op [$];
	word_t tab_addr [$];
	word_t tab_data [$];
	logic  tab_hit [$];

	int tests = 0;
	int checks = 0;
	int errors = 0;
	logic abort = 1'b0;

	// Memory beat state
	logic beat_active = 1'b0;
	int unsigned wait_left = 0;
	word_t lcg_state = 32'h4aea_b54b;

	dcache i_dcache (
		.CLK(CLK), .nRST(nRST), .halt(halt), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
		.dmemaddr(dmemaddr), .dmemstore(dmemstore), .dhit(dhit), .dmemload(dmemload),
		.flushed(flushed), .dwait(dwait), .dload(dload), .dREN(dREN), .dWEN(dWEN),
		.daddr(daddr), .dstore(dstore)
	);

	always #5 CLK = ~CLK;

	////////////////////
	// Helpers
	////////////////////
	function automatic word_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 16;
	endfunction

	function automatic word_t mem_word(input word_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return a ^ MEM_XOR;
	endfunction

	// What the processor should read back
	function automatic word_t expected_word(input word_t a);
		if (ref_mem.exists(a)) begin
			return ref_mem[a];
		end
		return a ^ MEM_XOR;
	endfunction

	function automatic int expected_hits();
		int n;
		n = 0;
		foreach (tab_op[i]) begin
			if ((tab_op[i] == OP_RD || tab_op[i] == OP_WR) && tab_hit[i]) begin
				n++;
			end
		end
		return n;
	endfunction

	function automatic string op_name(input int op);
		case (op)
			OP_RD: return "read";
			OP_WR: return "write";
			OP_MEM: return "memcheck";
			default: return "halt";
		endcase
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic add_entry(input int op, input word_t a, input word_t d, input logic h);
		tab_op.push_back(op);
		tab_addr.push_back(a);
		tab_data.push_back(d);
		tab_hit.push_back(h);
	endtask

	////////////////////
	// Memory model
	////////////////////
	// Decides dwait on each falling edge
	// The beat ends at the next rising edge
	always @(negedge CLK) begin
		if (!nRST) begin
			dwait = 1'b1;
			beat_active = 1'b0;
		end else if (dREN || dWEN) begin
			if (!beat_active) begin
				beat_active = 1'b1;
				wait_left = next_random() % 32'd4;
			end else if (wait_left != 0) begin
				wait_left = wait_left - 1;
			end
			if (wait_left == 0) begin
				dwait = 1'b0;
				beat_active = 1'b0;
				if (dWEN) begin
					mem[daddr] = dstore;
				end else begin
					dload = mem_word(daddr);
				end
			end else begin
				dwait = 1'b1;
			end
		end else begin
			dwait = 1'b1;
		end
	end

	////////////////////
	// Stimulus table
	////////////////////
	// Tags 0, 1 and 2 in set 2 evict the dirty way 0
	task automatic build_table();
		add_entry(OP_RD, 32'h0000_0010, '0, 1'b0);
		add_entry(OP_RD, 32'h0000_0014, '0, 1'b1);
		add_entry(OP_WR, 32'h0000_0014, 32'hA5A5_0001, 1'b1);
		add_entry(OP_RD, 32'h0000_0014, '0, 1'b1);
		add_entry(OP_RD, 32'h0000_0050, '0, 1'b0);
		add_entry(OP_RD, 32'h0000_0090, '0, 1'b0);
		// Both words of the evicted block reached memory
		add_entry(OP_MEM, 32'h0000_0014, '0, 1'b0);
		add_entry(OP_MEM, 32'h0000_0010, '0, 1'b0);
		add_entry(OP_RD, 32'h0000_0014, '0, 1'b0);
		add_entry(OP_WR, 32'h0000_0094, 32'h5A5A_0002, 1'b1);
		// Write miss in set 3 and a hit on its other word
		add_entry(OP_WR, 32'h0000_0118, 32'h1234_5678, 1'b0);
		add_entry(OP_RD, 32'h0000_011C, '0, 1'b1);
		add_entry(OP_WR, 32'h0000_0200, 32'h0F0F_3C3C, 1'b0);
		add_entry(OP_HALT, `DCACHE_COUNT_ADDR, '0, 1'b0);
	endtask

	// Samples just after the falling edge where outputs are settled
	task automatic wait_hit(output logic first, output logic ok);
		int cycles;
		cycles = 0;
		#1;
		first = dhit;
		while (!dhit && cycles < HIT_TIMEOUT) begin
			@(negedge CLK);
			#1;
			cycles++;
		end
		ok = dhit;
	endtask

	task automatic wait_flushed(output logic ok);
		int cycles;
		cycles = 0;
		#1;
		while (!flushed && cycles < FLUSH_TIMEOUT) begin
			@(negedge CLK);
			#1;
			cycles++;
		end
		ok = flushed;
	endtask

	task automatic run_entry(input int n);
		int op;
		word_t a;
		logic first;
		logic ok;
		int errs_before;
		op = tab_op[n];
		a = tab_addr[n];
		errs_before = errors;
		case (op)
			OP_RD, OP_WR: begin
				dmemaddr = a;
				dmemstore = tab_data[n];
				dmemREN = (op == OP_RD);
				dmemWEN = (op == OP_WR);
				wait_hit(first, ok);
				if (!ok) begin
					$display("test %0d: dhit never came within %0d cycles", n, HIT_TIMEOUT);
					errors++;
					abort = 1'b1;
				end else begin
					check_value("first try dhit", word_t'(first), word_t'(tab_hit[n]));
					if (op == OP_RD) begin
						check_value("dmemload", dmemload, expected_word(a));
					end else begin
						ref_mem[a] = tab_data[n];
					end
					// Hold through the hit edge and drop the request after it
					@(negedge CLK);
					dmemREN = 1'b0;
					dmemWEN = 1'b0;
					@(negedge CLK);
				end
			end
			OP_MEM: begin
				// The word must have come in through a write beat
				check_value($sformatf("mem[%h] written", a), word_t'(mem.exists(a)), 32'd1);
				check_value($sformatf("mem[%h]", a), mem_word(a), expected_word(a));
			end
			default: begin
				halt = 1'b1;
				wait_flushed(ok);
				if (!ok) begin
					$display("test %0d: flushed never rose within %0d cycles", n, FLUSH_TIMEOUT);
					errors++;
					abort = 1'b1;
				end else begin
					check_value("dREN", word_t'(dREN), '0);
					check_value("dWEN", word_t'(dWEN), '0);
					check_value("hit count word", mem_word(a), word_t'(expected_hits()));
					// Every written word must now be in memory
					foreach (ref_mem[w]) begin
						check_value($sformatf("mem[%h]", w), mem_word(w), ref_mem[w]);
					end
				end
			end
		endcase
		tests++;
		$display("test %0d %s %h %s", n, op_name(op), a, (errors == errs_before) ? "ok" : "bad");
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		nRST = 1'b0;
		halt = 1'b0;
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		dmemaddr = '0;
		dmemstore = '0;
		build_table();
		repeat (3) @(negedge CLK);
		nRST = 1'b1;
		@(negedge CLK);
		#1;
		// Quiet outputs out of reset
		check_value("dREN", word_t'(dREN), '0);
		check_value("dWEN", word_t'(dWEN), '0);
		check_value("flushed", word_t'(flushed), '0);
		check_value("dhit", word_t'(dhit), '0);
		tests++;
		$display("test reset %s", (errors == 0) ? "ok" : "bad");
		@(negedge CLK);
		for (int i = 0; i < tab_op.size() && !abort; i++) begin
			run_entry(i);
		end
		// Failed bound assertions count as errors too
		errors += i_dcache.i_props.fail_count;
		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_array.sv
verilog/dcache_lru.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
verification/dcache_props.sv
verification/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/dcache_sim

verilator --binary --timing --assert -Wno-fatal \
	--top-module dcache_tb -f files.f -o dcache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# Keep running after a failed assertion so the testbench reports it
"$SIM" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
